//--- branch_predictor.f
+incdir+common
+incdir+testbench
common/bp_types_pkg.sv
common/bp_hist_pkg.sv
common/bp_if.sv
logic/direction_predictor.sv
btb/branch_target_buffer.sv
logic/return_address_stack.sv
logic/prediction_stage.sv
logic/branch_predictor.sv
testbench/tb_branch_predictor.sv

//--- btb/branch_target_buffer.sv
`timescale 1ns/1ps
`include "bp_defs.svh"

module branch_target_buffer import bp_types_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_,
	input  logic                  fetch_valid,
	input  logic [`BP_ADDR_W-1:0] fetch_pc,
	bp_update_if.sink             upd,
	btb_lookup_if.source          lookup
);

	localparam int SET_W = $clog2(`BP_BTB_SETS);
	localparam int WAY_W = $clog2(`BP_BTB_WAYS);

	btb_entry_t                mem [`BP_BTB_WAYS][`BP_BTB_SETS];
	logic [`BP_BTB_WAYS-1:0]   valid_q [`BP_BTB_SETS];

	// fetch side
	logic [SET_W-1:0]          fetch_idx;
	logic [`BP_TAG_W-1:0]      fetch_tag;
	btb_entry_t                set_q [`BP_BTB_WAYS];
	logic [`BP_BTB_WAYS-1:0]   set_valid_q;
	logic [`BP_TAG_W-1:0]      tag_q;
	logic [`BP_BTB_WAYS-1:0]   hit_vec;
	logic [WAY_W-1:0]          hit_way;

	// update side
	logic [SET_W-1:0]          upd_idx;
	logic [`BP_TAG_W-1:0]      upd_tag;
	logic [`BP_BTB_WAYS-1:0]   upd_match;
	logic [WAY_W-1:0]          upd_way;
	logic                      upd_write;

	assign fetch_idx = fetch_pc[SET_W+1:2];
	assign fetch_tag = fetch_pc[SET_W+`BP_TAG_W+1:SET_W+2];
	assign upd_idx   = upd.pc[SET_W+1:2];
	assign upd_tag   = upd.pc[SET_W+`BP_TAG_W+1:SET_W+2];
	assign upd_write = upd.valid && (upd.branch_type != br_none);

	//////////////////////////////
	// lookup
	//////////////////////////////

	// set contents captured at the fetch edge
	always_ff @(posedge clk) begin
		tag_q <= fetch_tag;
		for (int w = 0; w < `BP_BTB_WAYS; w++) begin
			set_q[w] <= mem[w][fetch_idx];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_) begin
			set_valid_q <= '0;
		end else begin
			set_valid_q <= fetch_valid ? valid_q[fetch_idx] : '0;
		end
	end

	// tag compare, lowest way wins
	always_comb begin
		hit_way = '0;
		for (int w = `BP_BTB_WAYS - 1; w >= 0; w--) begin
			hit_vec[w] = set_valid_q[w] && (set_q[w].tag == tag_q);
			if (hit_vec[w]) begin
				hit_way = WAY_W'(w);
			end
		end
	end

	assign lookup.hit         = |hit_vec;
	assign lookup.branch_type = lookup.hit ? set_q[hit_way].btype : br_none;
	assign lookup.target      = lookup.hit ? set_q[hit_way].target : '0;

	//////////////////////////////
	// fill on resolve
	//////////////////////////////

	// matching way first, then first free way, else the last way
	always_comb begin
		upd_way = WAY_W'(`BP_BTB_WAYS - 1);
		for (int w = `BP_BTB_WAYS - 1; w >= 0; w--) begin
			if (!valid_q[upd_idx][w]) begin
				upd_way = WAY_W'(w);
			end
		end
		for (int w = `BP_BTB_WAYS - 1; w >= 0; w--) begin
			upd_match[w] = valid_q[upd_idx][w] && (mem[w][upd_idx].tag == upd_tag);
			if (upd_match[w]) begin
				upd_way = WAY_W'(w);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (upd_write) begin
			mem[upd_way][upd_idx] <= '{tag: upd_tag, btype: upd.branch_type, target: upd.target};
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_) begin
			for (int s = 0; s < `BP_BTB_SETS; s++) begin
				valid_q[s] <= '0;
			end
		end else if (upd_write) begin
			valid_q[upd_idx][upd_way] <= 1'b1;
		end
	end

	// replacement never leaves two copies of a tag in one set
	a_single_match: assert property (@(posedge clk) disable iff (!rst_)
		$onehot0(hit_vec));

endmodule

//--- common/bp_defs.svh
`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

//////////////////////////////
// global widths
//////////////////////////////

// instruction address
`define BP_ADDR_W 32

// global history, also the pht index width
`define BP_GHR_W 8

//////////////////////////////
// btb geometry
//////////////////////////////

`define BP_BTB_SETS 256
`define BP_BTB_WAYS 4
// tag is pc[19:10], set index is pc[9:2]
`define BP_TAG_W 10

// return address stack entries
`define BP_RAS_DEPTH 8

`endif

//--- common/bp_hist_pkg.sv
`include "bp_defs.svh"

package bp_hist_pkg;

	// global branch history, newest outcome in bit 0
	typedef logic [`BP_GHR_W-1:0] ghr_t;

	// pattern table index, same width as the history
	typedef logic [`BP_GHR_W-1:0] pht_index_t;

	// two-bit saturating counter, msb gives the direction
	typedef enum logic [1:0] {
		strong_not_taken = 2'b00,
		weak_not_taken   = 2'b01,
		weak_taken       = 2'b10,
		strong_taken     = 2'b11
	} counter_e;

endpackage

//--- common/bp_if.sv
`timescale 1ns/1ps
`include "bp_defs.svh"

//////////////////////////////
// resolved branch from execute
//////////////////////////////

interface bp_update_if import bp_types_pkg::*; ();
	logic                  valid;
	logic [`BP_ADDR_W-1:0] pc;
	logic                  taken;
	branch_type_e          branch_type;
	logic [`BP_ADDR_W-1:0] target;

	// direction predictor and btb both listen
	modport sink (
		input valid,
		input pc,
		input taken,
		input branch_type,
		input target
	);
endinterface

//////////////////////////////
// btb result, one cycle after fetch
//////////////////////////////

interface btb_lookup_if import bp_types_pkg::*; ();
	logic                  hit;
	branch_type_e          branch_type;
	logic [`BP_ADDR_W-1:0] target;

	modport source (
		output hit,
		output branch_type,
		output target
	);

	modport sink (
		input hit,
		input branch_type,
		input target
	);
endinterface

//////////////////////////////
// return address stack access
//////////////////////////////

interface ras_if ();
	logic                  push;
	logic                  pop;
	logic [`BP_ADDR_W-1:0] push_addr;
	logic [`BP_ADDR_W-1:0] top;

	modport control (
		output push,
		output pop,
		output push_addr,
		input  top
	);

	modport stack (
		input  push,
		input  pop,
		input  push_addr,
		output top
	);
endinterface

//--- common/bp_types_pkg.sv
`include "bp_defs.svh"

package bp_types_pkg;

	// branch kind as stored in the btb
	typedef enum logic [1:0] {
		br_none     = 2'b00,
		br_relative = 2'b01,
		br_call     = 2'b10,
		br_return   = 2'b11
	} branch_type_e;

	// one btb way, tag | type | target
	typedef struct packed {
		logic [`BP_TAG_W-1:0]  tag;
		branch_type_e          btype;
		logic [`BP_ADDR_W-1:0] target;
	} btb_entry_t;

endpackage

//--- logic/branch_predictor.sv
`timescale 1ns/1ps
`include "bp_defs.svh"

module branch_predictor import bp_types_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_,
	input  logic                  fetch_valid,
	input  logic [`BP_ADDR_W-1:0] fetch_pc,
	input  logic                  upd_valid,
	input  logic [`BP_ADDR_W-1:0] upd_pc,
	input  logic                  upd_taken,
	input  branch_type_e          upd_type,
	input  logic [`BP_ADDR_W-1:0] upd_target,
	output logic                  pred_valid,
	output logic [`BP_ADDR_W-1:0] pred_pc,
	output logic                  pred_taken,
	output branch_type_e          pred_type,
	output logic [`BP_ADDR_W-1:0] pred_target
);

	logic counter_taken;

	bp_update_if  upd_bus ();
	btb_lookup_if lookup_bus ();
	ras_if        ras_bus ();

	// resolved branch from execute
	assign upd_bus.valid       = upd_valid;
	assign upd_bus.pc          = upd_pc;
	assign upd_bus.taken       = upd_taken;
	assign upd_bus.branch_type = upd_type;
	assign upd_bus.target      = upd_target;

	direction_predictor direction_predictor_i (
		.clk           (clk),
		.rst_          (rst_),
		.fetch_valid   (fetch_valid),
		.fetch_pc      (fetch_pc),
		.upd           (upd_bus.sink),
		.counter_taken (counter_taken)
	);

	branch_target_buffer branch_target_buffer_i (
		.clk         (clk),
		.rst_        (rst_),
		.fetch_valid (fetch_valid),
		.fetch_pc    (fetch_pc),
		.upd         (upd_bus.sink),
		.lookup      (lookup_bus.source)
	);

	return_address_stack return_address_stack_i (
		.clk  (clk),
		.rst_ (rst_),
		.ras  (ras_bus.stack)
	);

	prediction_stage prediction_stage_i (
		.clk           (clk),
		.rst_          (rst_),
		.fetch_valid   (fetch_valid),
		.fetch_pc      (fetch_pc),
		.counter_taken (counter_taken),
		.lookup        (lookup_bus.sink),
		.ras           (ras_bus.control),
		.pred_valid    (pred_valid),
		.pred_pc       (pred_pc),
		.pred_taken    (pred_taken),
		.pred_type     (pred_type),
		.pred_target   (pred_target)
	);

endmodule

//--- logic/direction_predictor.sv
`timescale 1ns/1ps
`include "bp_defs.svh"

module direction_predictor import bp_types_pkg::*, bp_hist_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_,
	input  logic                  fetch_valid,
	input  logic [`BP_ADDR_W-1:0] fetch_pc,
	bp_update_if.sink             upd,
	output logic                  counter_taken
);

	localparam int PHT_SIZE = 1 << `BP_GHR_W;

	ghr_t       ghr;
	counter_e   pht [PHT_SIZE];
	pht_index_t fetch_idx;
	pht_index_t upd_idx;
	counter_e   fetch_ctr;
	logic       train;

	// gshare hash, folded pc bits xor history
	function automatic pht_index_t pht_hash(logic [`BP_ADDR_W-1:0] pc, ghr_t hist);
		return {pc[19:16] ^ pc[15:12], pc[11:8] ^ pc[7:4]} ^ hist;
	endfunction

	// saturating step toward the resolved direction
	function automatic counter_e step_counter(counter_e cur, logic taken);
		counter_e nxt;
		case (cur)
			strong_not_taken: nxt = taken ? weak_not_taken : strong_not_taken;
			weak_not_taken:   nxt = taken ? weak_taken : strong_not_taken;
			weak_taken:       nxt = taken ? strong_taken : weak_not_taken;
			default:          nxt = taken ? strong_taken : weak_taken;
		endcase
		return nxt;
	endfunction

	assign fetch_idx = pht_hash(fetch_pc, ghr);
	assign upd_idx   = pht_hash(upd.pc, ghr);
	assign fetch_ctr = pht[fetch_idx];
	// only conditional branches train the table
	assign train     = upd.valid && (upd.branch_type == br_relative);

	// history and pattern table
	always_ff @(posedge clk) begin
		if (!rst_) begin
			ghr <= '0;
			for (int i = 0; i < PHT_SIZE; i++) begin
				pht[i] <= weak_not_taken;
			end
		end else if (train) begin
			pht[upd_idx] <= step_counter(pht[upd_idx], upd.taken);
			ghr          <= {ghr[`BP_GHR_W-2:0], upd.taken};
		end
	end

	// counter msb for the fetch, seen one cycle later
	always_ff @(posedge clk) begin
		if (!rst_) begin
			counter_taken <= 1'b0;
		end else if (fetch_valid) begin
			counter_taken <= fetch_ctr[1];
		end
	end

	a_counter_known: assert property (@(posedge clk) disable iff (!rst_)
		!$isunknown(counter_taken));

endmodule

//--- logic/prediction_stage.sv
`timescale 1ns/1ps
`include "bp_defs.svh"

module prediction_stage import bp_types_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_,
	input  logic                  fetch_valid,
	input  logic [`BP_ADDR_W-1:0] fetch_pc,
	input  logic                  counter_taken,
	btb_lookup_if.sink            lookup,
	ras_if.control                ras,
	output logic                  pred_valid,
	output logic [`BP_ADDR_W-1:0] pred_pc,
	output logic                  pred_taken,
	output branch_type_e          pred_type,
	output logic [`BP_ADDR_W-1:0] pred_target
);

	logic is_call;
	logic is_return;

	always_ff @(posedge clk) begin
		if (!rst_) begin
			pred_valid <= 1'b0;
		end else begin
			pred_valid <= fetch_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_valid) begin
			pred_pc <= fetch_pc;
		end
	end

	// btb reports br_none on a miss
	assign pred_type = lookup.branch_type;
	assign is_call   = lookup.hit && (lookup.branch_type == br_call);
	assign is_return = lookup.hit && (lookup.branch_type == br_return);

	// calls and returns always taken, relative follows the counter
	assign pred_taken = is_call || is_return ||
		(lookup.hit && (lookup.branch_type == br_relative) && counter_taken);

	always_comb begin
		case (lookup.branch_type)
			br_relative, br_call: pred_target = lookup.target;
			br_return:            pred_target = ras.top;
			default:              pred_target = '0;
		endcase
	end

	// return point skips the delay slot
	assign ras.push      = pred_valid && is_call;
	assign ras.pop       = pred_valid && is_return;
	assign ras.push_addr = pred_pc + `BP_ADDR_W'(8);

endmodule

//--- logic/return_address_stack.sv
`timescale 1ns/1ps
`include "bp_defs.svh"

module return_address_stack (
	input  logic clk,
	input  logic rst_,
	ras_if.stack ras
);

	localparam int PTR_W = $clog2(`BP_RAS_DEPTH);

	logic [`BP_ADDR_W-1:0] stack_mem [`BP_RAS_DEPTH];
	// top_ptr points at the newest entry
	logic [PTR_W-1:0]      top_ptr;
	logic [PTR_W-1:0]      push_ptr;
	logic [PTR_W:0]        count;
	logic                  empty;
	logic                  full;

	assign push_ptr = top_ptr + PTR_W'(1);
	assign empty    = (count == '0);
	assign full     = (count == (PTR_W+1)'(`BP_RAS_DEPTH));

	assign ras.top = empty ? '0 : stack_mem[top_ptr];

	// ring write, a push on full lands on the oldest slot
	always_ff @(posedge clk) begin
		if (ras.push) begin
			stack_mem[push_ptr] <= ras.push_addr;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_) begin
			top_ptr <= '0;
			count   <= '0;
		end else if (ras.push) begin
			top_ptr <= push_ptr;
			if (!full) begin
				count <= count + 1'b1;
			end
		end else if (ras.pop && !empty) begin
			// pop on empty is ignored
			top_ptr <= top_ptr - PTR_W'(1);
			count   <= count - 1'b1;
		end
	end

	// a fetch is either a call or a return, never both
	a_no_push_pop: assert property (@(posedge clk) disable iff (!rst_)
		!(ras.push && ras.pop));

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the branch predictor testbench with verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_branch_predictor
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module "$TOP" -Mdir obj_dir -f branch_predictor.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/V$TOP > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
	echo "simulation failed"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi
echo "simulation passed"
exit 0

//--- testbench/bp_ref_model.svh
`ifndef BP_REF_MODEL_SVH
`define BP_REF_MODEL_SVH

//////////////////////////////
// reference model state
//////////////////////////////

typedef struct packed {
	logic                  taken;
	branch_type_e          btype;
	logic [`BP_ADDR_W-1:0] target;
} expect_t;

ghr_t                  m_ghr;
counter_e              m_pht [1 << `BP_GHR_W];
logic                  m_valid [`BP_BTB_SETS][`BP_BTB_WAYS];
logic [`BP_TAG_W-1:0]  m_tag [`BP_BTB_SETS][`BP_BTB_WAYS];
branch_type_e          m_type [`BP_BTB_SETS][`BP_BTB_WAYS];
logic [`BP_ADDR_W-1:0] m_target [`BP_BTB_SETS][`BP_BTB_WAYS];
// newest return address at the back
logic [`BP_ADDR_W-1:0] m_ras [$];

task automatic model_reset();
	m_ghr = '0;
	m_ras.delete();
	for (int i = 0; i < (1 << `BP_GHR_W); i++) begin
		m_pht[i] = weak_not_taken;
	end
	for (int s = 0; s < `BP_BTB_SETS; s++) begin
		for (int w = 0; w < `BP_BTB_WAYS; w++) begin
			m_valid[s][w] = 1'b0;
		end
	end
endtask

// folded pc bits xor current history
function automatic pht_index_t model_index(logic [`BP_ADDR_W-1:0] pc);
	logic [`BP_GHR_W-1:0] folded;
	folded = {pc[19:16] ^ pc[15:12], pc[11:8] ^ pc[7:4]};
	return folded ^ m_ghr;
endfunction

// lowest valid way with a matching tag or -1
function automatic int model_find_way(logic [`BP_ADDR_W-1:0] pc);
	int idx;
	int way;
	idx = int'(pc[9:2]);
	way = -1;
	for (int w = `BP_BTB_WAYS - 1; w >= 0; w--) begin
		if (m_valid[idx][w] && m_tag[idx][w] == pc[19:10]) begin
			way = w;
		end
	end
	return way;
endfunction

task automatic model_update(input logic [`BP_ADDR_W-1:0] pc, input logic taken,
		input branch_type_e btype, input logic [`BP_ADDR_W-1:0] target);
	int         idx;
	int         way;
	pht_index_t pi;
	logic [1:0] ctr;
	if (btype == br_relative) begin
		pi  = model_index(pc);
		ctr = m_pht[pi];
		if (taken && ctr != 2'b11) begin
			ctr = ctr + 2'b01;
		end else if (!taken && ctr != 2'b00) begin
			ctr = ctr - 2'b01;
		end
		m_pht[pi] = counter_e'(ctr);
		m_ghr     = {m_ghr[`BP_GHR_W-2:0], taken};
	end
	if (btype != br_none) begin
		idx = int'(pc[9:2]);
		way = model_find_way(pc);
		// without a tag match take the first free way or the last one
		if (way < 0) begin
			way = `BP_BTB_WAYS - 1;
			for (int w = `BP_BTB_WAYS - 1; w >= 0; w--) begin
				if (!m_valid[idx][w]) begin
					way = w;
				end
			end
		end
		m_valid[idx][way]  = 1'b1;
		m_tag[idx][way]    = pc[19:10];
		m_type[idx][way]   = btype;
		m_target[idx][way] = target;
	end
endtask

function automatic expect_t ref_predict(logic [`BP_ADDR_W-1:0] pc);
	expect_t  e;
	int       idx;
	int       way;
	counter_e ctr;
	idx = int'(pc[9:2]);
	way = model_find_way(pc);
	e   = '{taken: 1'b0, btype: br_none, target: '0};
	if (way >= 0) begin
		e.btype = m_type[idx][way];
		ctr     = m_pht[model_index(pc)];
		case (e.btype)
			br_relative: begin
				e.taken  = (ctr == weak_taken) || (ctr == strong_taken);
				e.target = m_target[idx][way];
			end
			br_call: begin
				e.taken  = 1'b1;
				e.target = m_target[idx][way];
			end
			br_return: begin
				e.taken  = 1'b1;
				e.target = (m_ras.size() != 0) ? m_ras[m_ras.size() - 1] : '0;
			end
			default: e.taken = 1'b0;
		endcase
	end
	return e;
endfunction

// stack effect of a prediction that has been checked
task automatic model_retire(input logic [`BP_ADDR_W-1:0] pc, input expect_t e);
	if (e.btype == br_call) begin
		m_ras.push_back(pc + 32'd8);
		if (m_ras.size() > `BP_RAS_DEPTH) begin
			m_ras.delete(0);
		end
	end else if (e.btype == br_return && m_ras.size() != 0) begin
		m_ras.delete(m_ras.size() - 1);
	end
endtask

//////////////////////////////
// compare tasks
//////////////////////////////

task automatic check_valid(input bit exp, input logic got);
	if (got !== exp) begin
		abort_run($sformatf("** Error: pred_valid expected %h got %h", exp, got));
	end
endtask

task automatic check_taken(input bit exp, input logic got);
	if (got !== exp) begin
		abort_run($sformatf("** Error: pred_taken expected %h got %h", exp, got));
	end
endtask

task automatic check_type(input branch_type_e exp, input branch_type_e got);
	if (got !== exp) begin
		abort_run($sformatf("** Error: pred_type expected %h got %h", exp, got));
	end
endtask

task automatic check_target(input string name, input logic [`BP_ADDR_W-1:0] exp,
		input logic [`BP_ADDR_W-1:0] got);
	if (got !== exp) begin
		abort_run($sformatf("** Error: %s expected %h got %h", name, exp, got));
	end
endtask

`endif

//--- testbench/tb_branch_predictor.sv
`timescale 1ns/1ps
`include "bp_defs.svh"

module tb_branch_predictor import bp_types_pkg::*, bp_hist_pkg::*; ();

	localparam int WAIT_LIMIT = 100;

	logic                  clk;
	logic                  rst_;
	logic                  fetch_valid;
	logic [`BP_ADDR_W-1:0] fetch_pc;
	logic                  upd_valid;
	logic [`BP_ADDR_W-1:0] upd_pc;
	logic                  upd_taken;
	branch_type_e          upd_type;
	logic [`BP_ADDR_W-1:0] upd_target;
	logic                  pred_valid;
	logic [`BP_ADDR_W-1:0] pred_pc;
	logic                  pred_taken;
	branch_type_e          pred_type;
	logic [`BP_ADDR_W-1:0] pred_target;

`include "bp_ref_model.svh"

	integer                seed;
	// fetched pcs still waiting for their prediction
	logic [`BP_ADDR_W-1:0] pc_q [$];
	logic [`BP_ADDR_W-1:0] cmp_pc;
	expect_t               cmp_exp;
	logic [`BP_ADDR_W-1:0] inst_pc [8];
	// fetch taken in at the last rising edge
	logic                  fetch_sampled;

	branch_predictor branch_predictor_i (.*);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("CHECKS FAILED");
		$fatal(1, "stopped at first failure");
	endtask

	//////////////////////////////
	// stimulus
	//////////////////////////////

	task automatic drive_fetch(input logic [`BP_ADDR_W-1:0] pc);
		fetch_valid = 1'b1;
		fetch_pc    = pc;
		pc_q.push_back(pc);
		@(posedge clk);
		#1;
		fetch_valid = 1'b0;
	endtask

	task automatic wait_predictions();
		int cycles;
		cycles = 0;
		while (pc_q.size() != 0) begin
			if (cycles == WAIT_LIMIT) begin
				abort_run("timed out waiting for pred_valid");
			end
			cycles++;
			@(posedge clk);
			#1;
		end
	endtask

	task automatic fetch_one(input logic [`BP_ADDR_W-1:0] pc);
		drive_fetch(pc);
		wait_predictions();
	endtask

	task automatic drive_update(input logic [`BP_ADDR_W-1:0] pc, input logic taken,
			input branch_type_e btype, input logic [`BP_ADDR_W-1:0] target);
		upd_valid  = 1'b1;
		upd_pc     = pc;
		upd_taken  = taken;
		upd_type   = btype;
		upd_target = target;
		@(posedge clk);
		#1;
		upd_valid = 1'b0;
		model_update(pc, taken, btype, target);
	endtask

	// one cycle of latency from fetch to prediction
	always @(posedge clk) begin
		fetch_sampled <= rst_ && fetch_valid;
	end

	// compare each cycle at the falling edge
	always @(negedge clk) begin
		if (rst_ === 1'b1) begin
			check_valid(fetch_sampled, pred_valid);
			if (pred_valid === 1'b1) begin
				cmp_pc  = pc_q.pop_front();
				cmp_exp = ref_predict(cmp_pc);
				check_target("pred_pc", cmp_pc, pred_pc);
				check_taken(cmp_exp.taken, pred_taken);
				check_type(cmp_exp.btype, pred_type);
				check_target("pred_target", cmp_exp.target, pred_target);
				model_retire(cmp_pc, cmp_exp);
			end
		end
	end

	//////////////////////////////
	// scenarios
	//////////////////////////////

	initial begin
		seed          = 32'ha981;
		rst_          = 1'b0;
		fetch_valid   = 1'b0;
		fetch_pc      = '0;
		upd_valid     = 1'b0;
		upd_pc        = '0;
		upd_taken     = 1'b0;
		upd_type      = br_none;
		upd_target    = '0;
		model_reset();
		repeat (10) @(posedge clk);
		#1;
		rst_ = 1'b1;

		// everything misses in the empty btb
		for (int i = 0; i < 16; i++) begin
			drive_fetch(32'($random(seed)));
		end
		wait_predictions();

		// one relative branch trained by a taken run and a not taken run
		drive_update(32'h0000_4a10, 1'b1, br_relative, 32'h0000_5000);
		fetch_one(32'h0000_4a10);
		for (int i = 0; i < 24; i++) begin
			drive_update(32'h0000_4a10, (i < 10) || (i >= 18), br_relative, 32'h0000_5000);
			fetch_one(32'h0000_4a10);
		end

		// single call and return and then a nested pair back to back
		drive_update(32'h0001_0100, 1'b1, br_call, 32'h0000_2000);
		drive_update(32'h0001_0200, 1'b1, br_call, 32'h0000_3000);
		drive_update(32'h0001_0300, 1'b1, br_return, 32'h0000_0000);
		fetch_one(32'h0001_0100);
		fetch_one(32'h0001_0300);
		drive_fetch(32'h0001_0100);
		drive_fetch(32'h0001_0200);
		drive_fetch(32'h0001_0300);
		drive_fetch(32'h0001_0300);
		wait_predictions();

		// ten calls overflow the stack
		for (int i = 0; i < 10; i++) begin
			drive_update(32'h0002_0000 + 32'(i * 64), 1'b1, br_call, 32'h0003_0000 + 32'(i * 4));
		end
		for (int i = 0; i < 10; i++) begin
			drive_fetch(32'h0002_0000 + 32'(i * 64));
		end
		for (int i = 0; i < 10; i++) begin
			drive_fetch(32'h0001_0300);
		end
		wait_predictions();

		// five tags in set 0xf0 where the fifth evicts way 3
		for (int i = 0; i < 5; i++) begin
			drive_update(32'h0005_03c0 + 32'(i * 1024), 1'b1, br_relative,
				32'h0006_0000 + 32'(i * 16));
			if (i >= 3) begin
				for (int j = 0; j <= i; j++) begin
					drive_fetch(32'h0005_03c0 + 32'(j * 1024));
				end
				wait_predictions();
			end
		end

		// random installs and then a fetch every cycle
		for (int i = 0; i < 8; i++) begin
			inst_pc[i] = 32'($random(seed)) & 32'hffff_fffc;
			drive_update(inst_pc[i], 1'($random(seed)),
				branch_type_e'(2'(1 + $unsigned($random(seed)) % 3)), 32'($random(seed)));
		end
		for (int i = 0; i < 48; i++) begin
			if (1'($random(seed))) begin
				drive_fetch(inst_pc[$unsigned($random(seed)) % 8]);
			end else begin
				drive_fetch(32'($random(seed)) & 32'hffff_fffc);
			end
		end
		wait_predictions();

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule
